/* hw/sched_pkg.sv */
// Scheduler package with the requester sizes, the tie-break mode and the round-robin state types
package sched_pkg;

  // Number of requesters feeding the scheduler
  localparam int NUM_REQ = 8;

  // Width of a requester index, NUM_REQ is exactly 2**REQ_IDX_W so index sums wrap on their own
  localparam int REQ_IDX_W = 3;

  // Width of a wait-age counter
  localparam int AGE_W = 4;

  // Saturation value of a wait age
  localparam logic [AGE_W-1:0] AGE_MAX = {AGE_W{1'b1}};

  // Tie-break applied among requests that share the largest age
  typedef enum logic {
    TIE_STRICT = 1'b0,
    TIE_RR     = 1'b1
  } tie_mode_e;

  // State of the round-robin priority pointer
  // RR_IDLE starts priority at index 0 because nothing has been granted yet
  // RR_ARMED means the pointer holds the index after the last winner
  typedef enum logic {
    RR_IDLE  = 1'b0,
    RR_ARMED = 1'b1
  } rr_state_e;

endpackage

/* hw/age_tracker.sv */
// Decode stage that turns request strobes into pending flags and saturating wait ages
module age_tracker
  import sched_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [NUM_REQ-1:0]         req_set,
  input  logic                       clr_v,
  input  logic [REQ_IDX_W-1:0]       clr_id,
  output logic [NUM_REQ-1:0]         pending,
  output logic [NUM_REQ*AGE_W-1:0]   ages
);

  // One-hot form of the clear command from the arbiter
  logic [NUM_REQ-1:0] clr_hit;

  // Decode the granted index so each requester sees its own clear bit
  always_comb begin
    clr_hit = '0;
    if (clr_v) begin
      clr_hit[clr_id] = 1'b1;
    end
  end

  // Per-requester pending flag and wait counter
  // Ages are packed with requester i in bits i*AGE_W and up
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
      ages    <= '0;
    end else begin
      for (int i = 0; i < NUM_REQ; i++) begin
        if (req_set[i] && (!pending[i] || clr_hit[i])) begin
          // A new request on an idle slot starts waiting from age 0
          // A strobe landing in the grant cycle wins over the clear and restarts the age
          pending[i]               <= 1'b1;
          ages[i*AGE_W +: AGE_W]   <= '0;
        end else if (clr_hit[i]) begin
          // Granted without a fresh strobe so the slot goes idle
          pending[i]               <= 1'b0;
          ages[i*AGE_W +: AGE_W]   <= '0;
        end else if (pending[i] && (ages[i*AGE_W +: AGE_W] != AGE_MAX)) begin
          // Still waiting, count one more cycle until the counter saturates
          ages[i*AGE_W +: AGE_W]   <= ages[i*AGE_W +: AGE_W] + 1'b1;
        end
        // A strobe on a slot that is pending and not granted falls through here
        // The request is already recorded and its age keeps its running value
      end
    end
  end

endmodule

/* hw/rr_pick.sv */
// Round-robin tie-break that picks the first candidate at or after a rotating pointer
module rr_pick
  import sched_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_REQ-1:0]   cand,
  input  logic                 en,
  output logic                 pick_v,
  output logic [REQ_IDX_W-1:0] pick_id
);

  // Pointer state and the index holding top priority once armed
  rr_state_e            rr_state;
  logic [REQ_IDX_W-1:0] ptr;

  // Start of the search and the index being probed
  logic [REQ_IDX_W-1:0] base;
  logic [REQ_IDX_W-1:0] idx;

  // Scan the candidates starting at base
  // The sum wraps in REQ_IDX_W bits which gives the modulo NUM_REQ walk
  always_comb begin
    base    = (rr_state == RR_IDLE) ? '0 : ptr;
    pick_v  = 1'b0;
    pick_id = '0;
    idx     = base;
    for (int k = 0; k < NUM_REQ; k++) begin
      idx = base + REQ_IDX_W'(k);
      if (!pick_v && cand[idx]) begin
        pick_v  = 1'b1;
        pick_id = idx;
      end
    end
  end

  // Advance the pointer past the winner whenever a pick is used
  // The first used pick also arms the pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_state <= RR_IDLE;
      ptr      <= '0;
    end else if (en && pick_v) begin
      rr_state <= RR_ARMED;
      ptr      <= pick_id + 1'b1;
    end
  end

endmodule

/* hw/oldest_arb.sv */
// Execute stage that keeps only the oldest pending requests and picks one by the tie-break mode
module oldest_arb
  import sched_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [NUM_REQ-1:0]       pending,
  input  logic [NUM_REQ*AGE_W-1:0] ages,
  input  logic                     arb_en,
  input  tie_mode_e                tie_mode,
  output logic                     win_v,
  output logic [REQ_IDX_W-1:0]     win_id,
  output logic [AGE_W-1:0]         win_age
);

  // Pending requests that no other pending request is strictly older than
  logic [NUM_REQ-1:0]   oldest_mask;

  // Strict pick, lowest index among the oldest
  logic                 strict_v;
  logic [REQ_IDX_W-1:0] strict_id;

  // Round-robin pick and its pointer update enable
  logic                 rr_v;
  logic [REQ_IDX_W-1:0] rr_id;
  logic                 rr_en;

  // Pairwise compare of every pending request against every other one
  // Request i drops out as soon as some pending j has a larger age
  always_comb begin
    oldest_mask = pending;
    for (int i = 0; i < NUM_REQ; i++) begin
      for (int j = 0; j < NUM_REQ; j++) begin
        if ((i != j) && pending[i] && pending[j] &&
            (ages[i*AGE_W +: AGE_W] < ages[j*AGE_W +: AGE_W])) begin
          oldest_mask[i] = 1'b0;
        end
      end
    end
  end

  // Lowest set bit of the oldest mask
  always_comb begin
    strict_v  = 1'b0;
    strict_id = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (!strict_v && oldest_mask[i]) begin
        strict_v  = 1'b1;
        strict_id = REQ_IDX_W'(i);
      end
    end
  end

  // The pointer only moves on cycles that actually grant in round-robin mode
  assign rr_en = arb_en && (tie_mode == TIE_RR);

  rr_pick rr_pick_i (
    .clk     (clk),
    .rst     (rst),
    .cand    (oldest_mask),
    .en      (rr_en),
    .pick_v  (rr_v),
    .pick_id (rr_id)
  );

  // Mode select, then arb_en decides whether the cycle grants at all
  assign win_v   = arb_en && ((tie_mode == TIE_RR) ? rr_v : strict_v);
  assign win_id  = (tie_mode == TIE_RR) ? rr_id : strict_id;
  assign win_age = ages[win_id*AGE_W +: AGE_W];

endmodule

/* hw/grant_issue.sv */
// Result stage that registers the grant pulse and tracks the longest granted wait
module grant_issue
  import sched_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 win_v,
  input  logic [REQ_IDX_W-1:0] win_id,
  input  logic [AGE_W-1:0]     win_age,
  output logic                 grant_v,
  output logic [REQ_IDX_W-1:0] grant_id,
  output logic [NUM_REQ-1:0]   grant_onehot,
  output logic [AGE_W-1:0]     grant_age,
  output logic [AGE_W-1:0]     max_wait
);

  // Decoded winner vector, registered alongside the index
  logic [NUM_REQ-1:0] win_onehot;

  always_comb begin
    win_onehot         = '0;
    win_onehot[win_id] = 1'b1;
  end

  // Grant pulse lasts exactly one cycle per win
  // The one-hot vector is zero between grants so it never shows a stale owner
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_v      <= 1'b0;
      grant_onehot <= '0;
    end else begin
      grant_v      <= win_v;
      grant_onehot <= win_v ? win_onehot : '0;
    end
  end

  // Index and age hold their last values while no grant is issued
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_id  <= '0;
      grant_age <= '0;
    end else if (win_v) begin
      grant_id  <= win_id;
      grant_age <= win_age;
    end
  end

  // Running maximum of every granted age since reset
  // It updates on the same edge as grant_age so both agree in the grant cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      max_wait <= '0;
    end else if (win_v && (win_age > max_wait)) begin
      max_wait <= win_age;
    end
  end

endmodule

/* hw/age_sched_top.sv */
// Top level of the age-ordered scheduler joining the decode, execute and result stages
module age_sched_top
  import sched_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_REQ-1:0]   req_set,
  input  logic                 arb_en,
  input  tie_mode_e            tie_mode,
  output logic                 grant_v,
  output logic [REQ_IDX_W-1:0] grant_id,
  output logic [NUM_REQ-1:0]   grant_onehot,
  output logic [AGE_W-1:0]     grant_age,
  output logic [AGE_W-1:0]     max_wait
);

  // Age picture from the decode stage
  logic [NUM_REQ-1:0]       pending;
  logic [NUM_REQ*AGE_W-1:0] ages;

  // Winner from the execute stage, also the clear command back to the tracker
  logic                     win_v;
  logic [REQ_IDX_W-1:0]     win_id;
  logic [AGE_W-1:0]         win_age;

  age_tracker age_tracker_i (
    .clk     (clk),
    .rst     (rst),
    .req_set (req_set),
    .clr_v   (win_v),
    .clr_id  (win_id),
    .pending (pending),
    .ages    (ages)
  );

  oldest_arb oldest_arb_i (
    .clk      (clk),
    .rst      (rst),
    .pending  (pending),
    .ages     (ages),
    .arb_en   (arb_en),
    .tie_mode (tie_mode),
    .win_v    (win_v),
    .win_id   (win_id),
    .win_age  (win_age)
  );

  grant_issue grant_issue_i (
    .clk          (clk),
    .rst          (rst),
    .win_v        (win_v),
    .win_id       (win_id),
    .win_age      (win_age),
    .grant_v      (grant_v),
    .grant_id     (grant_id),
    .grant_onehot (grant_onehot),
    .grant_age    (grant_age),
    .max_wait     (max_wait)
  );

endmodule

/* tests/age_sched_assert.sv */
// Bound checker for the scheduler grant outputs covering one-hot form, pulse shape and reset state
module age_sched_assert
  import sched_pkg::*;
(
  input logic                 clk,
  input logic                 rst,
  input logic                 grant_v,
  input logic [REQ_IDX_W-1:0] grant_id,
  input logic [NUM_REQ-1:0]   grant_onehot,
  input logic [AGE_W-1:0]     grant_age,
  input logic [AGE_W-1:0]     max_wait
);
  timeunit 1ns;
  timeprecision 100ps;

  // A grant names exactly one requester and that bit matches the index
  onehot_matches_id: assert property (@(posedge clk) disable iff (rst)
    grant_v |-> (grant_onehot == (NUM_REQ'(1) << grant_id)))
    else $error("grant_onehot does not carry the single bit of grant_id");

  // Between grants the one-hot vector stays clear
  onehot_idle_clear: assert property (@(posedge clk) disable iff (rst)
    !grant_v |-> (grant_onehot == '0))
    else $error("grant_onehot is set while grant_v is low");

  // A grant is a single pulse, the same requester only returns next cycle
  // when it was strobed again in its grant cycle and so restarted at age 0
  grant_single_pulse: assert property (@(posedge clk) disable iff (rst)
    (grant_v && $past(grant_v) && (grant_id == $past(grant_id))) |-> (grant_age == '0))
    else $error("grant held for the same requester without a fresh request");

  // The running maximum never falls below the age just granted
  max_covers_grant: assert property (@(posedge clk) disable iff (rst)
    grant_v |-> (max_wait >= grant_age))
    else $error("max_wait is below the granted age");

  // Every output is quiet in the cycle after a reset edge
  quiet_after_reset: assert property (@(posedge clk)
    $past(rst) |-> (!grant_v && (grant_onehot == '0) && (grant_id == '0) &&
                    (grant_age == '0) && (max_wait == '0)))
    else $error("grant outputs not at their reset values after reset");

endmodule

bind age_sched_top age_sched_assert assert_i (
  .clk          (clk),
  .rst          (rst),
  .grant_v      (grant_v),
  .grant_id     (grant_id),
  .grant_onehot (grant_onehot),
  .grant_age    (grant_age),
  .max_wait     (max_wait)
);

/* tests/age_sched_tb.sv */
// Testbench for the age-ordered scheduler with a stimulus table, a random phase and a cycle model
module age_sched_tb
  import sched_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD_NS    = 8;
  localparam int RESET_CYCLES = 4;
  localparam int RAND_CYCLES  = 300;
  localparam int NUM_STEPS    = 24;

  // One table row holds the inputs for a run of identical cycles
  typedef struct packed {
    logic [NUM_REQ-1:0] req;
    logic               en;
    tie_mode_e          mode;
    logic [7:0]         reps;
  } step_t;

  logic                 clk;
  logic                 rst;
  logic [NUM_REQ-1:0]   req_set;
  logic                 arb_en;
  tie_mode_e            tie_mode;
  logic                 grant_v;
  logic [REQ_IDX_W-1:0] grant_id;
  logic [NUM_REQ-1:0]   grant_onehot;
  logic [AGE_W-1:0]     grant_age;
  logic [AGE_W-1:0]     max_wait;

  // Reference model state mirroring what the DUT registers should hold
  logic                 m_pend [NUM_REQ];
  logic [AGE_W-1:0]     m_age [NUM_REQ];
  int                   m_ptr;
  bit                   m_armed;

  // Expected outputs after the next rising edge
  logic                 exp_v;
  logic [REQ_IDX_W-1:0] exp_id;
  logic [NUM_REQ-1:0]   exp_oh;
  logic [AGE_W-1:0]     exp_age;
  logic [AGE_W-1:0]     exp_max;

  int     errors;
  int     checks;
  int     grants;
  integer seed = 32'h09ad_37ae;

  // Steps run idle, saturation, oldest-first, strict ties, round-robin bursts and strobe corners
  step_t steps [NUM_STEPS] = '{
    '{8'h00, 1'b0, TIE_STRICT, 8'd4},  '{8'h00, 1'b1, TIE_STRICT, 8'd3},
    '{8'h81, 1'b0, TIE_STRICT, 8'd1},  '{8'h00, 1'b0, TIE_STRICT, 8'd20},
    '{8'h00, 1'b1, TIE_STRICT, 8'd3},  '{8'h04, 1'b0, TIE_STRICT, 8'd1},
    '{8'h10, 1'b0, TIE_STRICT, 8'd1},  '{8'h01, 1'b0, TIE_STRICT, 8'd2},
    '{8'h00, 1'b1, TIE_STRICT, 8'd4},  '{8'h5A, 1'b0, TIE_STRICT, 8'd1},
    '{8'h00, 1'b1, TIE_STRICT, 8'd5},  '{8'hFF, 1'b0, TIE_RR,     8'd1},
    '{8'h00, 1'b1, TIE_RR,     8'd9},  '{8'h33, 1'b0, TIE_RR,     8'd1},
    '{8'h00, 1'b1, TIE_RR,     8'd5},  '{8'hCC, 1'b0, TIE_RR,     8'd1},
    '{8'h00, 1'b1, TIE_RR,     8'd5},  '{8'h02, 1'b0, TIE_RR,     8'd1},
    '{8'h08, 1'b0, TIE_RR,     8'd2},  '{8'h02, 1'b0, TIE_RR,     8'd1},
    '{8'h00, 1'b0, TIE_RR,     8'd1},  '{8'h02, 1'b1, TIE_RR,     8'd1},
    '{8'h00, 1'b1, TIE_RR,     8'd3},  '{8'h00, 1'b0, TIE_STRICT, 8'd2}
  };

  age_sched_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .req_set      (req_set),
    .arb_en       (arb_en),
    .tie_mode     (tie_mode),
    .grant_v      (grant_v),
    .grant_id     (grant_id),
    .grant_onehot (grant_onehot),
    .grant_age    (grant_age),
    .max_wait     (max_wait)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Compare the grant pulse, index and one-hot vector with the model
  task automatic check_grant(input logic got_v, input logic want_v,
                             input logic [REQ_IDX_W-1:0] got_id,
                             input logic [REQ_IDX_W-1:0] want_id,
                             input logic [NUM_REQ-1:0] got_oh,
                             input logic [NUM_REQ-1:0] want_oh);
    checks++;
    if (got_v !== want_v) begin
      errors++;
      $display("Mismatch at %0d ns: grant_v got %0b expected %0b", $time, got_v, want_v);
    end
    if (got_id !== want_id) begin
      errors++;
      $display("Mismatch at %0d ns: grant_id got %0d expected %0d", $time, got_id, want_id);
    end
    if (got_oh !== want_oh) begin
      errors++;
      $display("Mismatch at %0d ns: grant_onehot got %h expected %h", $time, got_oh, want_oh);
    end
  endtask

  // Compare any AGE_W wide value such as the granted age or the running maximum
  task automatic check_age(input string name, input logic [AGE_W-1:0] got,
                           input logic [AGE_W-1:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, want);
    end
  endtask

  // Advance the model by one edge for the inputs of this cycle
  task automatic model_step(input logic [NUM_REQ-1:0] req, input logic en,
                            input tie_mode_e mode);
    logic [NUM_REQ-1:0] oldest;
    bit found;
    int win;
    int base;
    int idx;
    // Keep a pending request unless another pending one is strictly older
    for (int i = 0; i < NUM_REQ; i++) begin
      oldest[i] = m_pend[i];
      for (int j = 0; j < NUM_REQ; j++) begin
        if (m_pend[i] && m_pend[j] && (m_age[j] > m_age[i])) oldest[i] = 1'b0;
      end
    end
    // Strict search starts at 0 and round robin starts at the pointer once armed
    found = 1'b0;
    win   = 0;
    base  = (mode == TIE_RR && m_armed) ? m_ptr : 0;
    for (int k = 0; k < NUM_REQ; k++) begin
      idx = (base + k) % NUM_REQ;
      if (!found && oldest[idx]) begin
        found = 1'b1;
        win   = idx;
      end
    end
    found  = found && en;
    exp_v  = found;
    exp_oh = '0;
    if (found) begin
      grants++;
      exp_id      = REQ_IDX_W'(win);
      exp_oh[win] = 1'b1;
      exp_age     = m_age[win];
      if (m_age[win] > exp_max) exp_max = m_age[win];
      if (mode == TIE_RR) begin
        m_armed = 1'b1;
        m_ptr   = (win + 1) % NUM_REQ;
      end
    end
    // Update pending flags and ages where a strobe in the grant cycle beats the clear
    for (int i = 0; i < NUM_REQ; i++) begin
      if (req[i] && (!m_pend[i] || (found && win == i))) begin
        m_pend[i] = 1'b1;
        m_age[i]  = '0;
      end else if (found && win == i) begin
        m_pend[i] = 1'b0;
        m_age[i]  = '0;
      end else if (m_pend[i] && m_age[i] != AGE_MAX) begin
        m_age[i] = m_age[i] + 1'b1;
      end
    end
  endtask

  // Check the outputs of the last edge, then drive and predict the next one
  task automatic apply_cycle(input logic [NUM_REQ-1:0] req, input logic en,
                             input tie_mode_e mode);
    @(negedge clk);
    check_grant(grant_v, exp_v, grant_id, exp_id, grant_onehot, exp_oh);
    check_age("grant_age", grant_age, exp_age);
    check_age("max_wait", max_wait, exp_max);
    req_set  = req;
    arb_en   = en;
    tie_mode = mode;
    model_step(req, en, mode);
  endtask

  function automatic int table_cycles();
    int total;
    total = 0;
    foreach (steps[s]) total += int'(steps[s].reps);
    return total;
  endfunction

  // Watchdog sized from the table and random phase with a factor two margin
  initial begin
    int limit_ns;
    limit_ns = (RESET_CYCLES + table_cycles() + RAND_CYCLES) * PERIOD_NS * 2;
    #(limit_ns);
    $display("Timeout after %0d ns, the stimulus did not complete", limit_ns);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    integer r;
    logic [NUM_REQ-1:0] rnd_req;
    logic rnd_en;
    tie_mode_e rnd_mode;
    rst      = 1'b1;
    req_set  = '0;
    arb_en   = 1'b0;
    tie_mode = TIE_STRICT;
    errors   = 0;
    checks   = 0;
    grants   = 0;
    for (int i = 0; i < NUM_REQ; i++) begin
      m_pend[i] = 1'b0;
      m_age[i]  = '0;
    end
    m_ptr   = 0;
    m_armed = 1'b0;
    exp_v   = 1'b0;
    exp_id  = '0;
    exp_oh  = '0;
    exp_age = '0;
    exp_max = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (steps[s]) begin
      for (int n = 0; n < int'(steps[s].reps); n++) begin
        apply_cycle(steps[s].req, steps[s].en, steps[s].mode);
      end
    end
    // Random strobes are sparse and arb_en is high three cycles in four
    // The mode only flips in cycles where arb_en is low
    rnd_mode = tie_mode;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      r       = $random(seed);
      rnd_req = r[7:0] & r[15:8];
      rnd_en  = r[16] | r[17];
      if (!rnd_en && r[18]) rnd_mode = (rnd_mode == TIE_RR) ? TIE_STRICT : TIE_RR;
      apply_cycle(rnd_req, rnd_en, rnd_mode);
    end
    @(negedge clk);
    check_grant(grant_v, exp_v, grant_id, exp_id, grant_onehot, exp_oh);
    check_age("grant_age", grant_age, exp_age);
    check_age("max_wait", max_wait, exp_max);
    $display("Checks: %0d, grants: %0d, errors: %0d", checks, grants, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* age_sched_top.f */
hw/sched_pkg.sv
hw/age_tracker.sv
hw/rr_pick.sv
hw/oldest_arb.sv
hw/grant_issue.sv
hw/age_sched_top.sv
tests/age_sched_assert.sv
tests/age_sched_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = age_sched_tb
FILELIST  = age_sched_top.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
